// ==== project.f ====
design/rv_serial_pkg.sv
design/serial_ctrl_if.sv
design/instr_fetch.sv
design/serial_decode.sv
design/serial_regfile.sv
design/serial_alu.sv
design/result_port.sv
design/serial_core_top.sv
tests/tb_clock.sv
tests/serial_core_chk.sv
tests/serial_core_tb.sv

// ==== tests/serial_core_tb.sv ====
`timescale 1ns/1ps

module serial_core_tb;

   localparam int N_INSTR        = 200;
   localparam int TIMEOUT_CYCLES = N_INSTR * 60 + 100;

   logic                     clk;
   logic                     i_rst;
   logic                     i_ins_req;
   rv_serial_pkg::word_t     i_ins_data;
   logic                     o_ins_ack;
   logic                     o_res_req;
   rv_serial_pkg::reg_addr_t o_res_rd;
   rv_serial_pkg::word_t     o_res_data;
   logic                     i_res_ack;

   rv_serial_pkg::word_t     model_regs [32];   // x0 stays zero
   rv_serial_pkg::word_t     exp_val_q [$];
   rv_serial_pkg::reg_addr_t exp_rd_q [$];
   string                    exp_name_q [$];
   int unsigned              delay_q [$];       // responder back-pressure
   int                       errors = 0;
   int                       sent = 0;
   int                       received = 0;
   int                       cycles = 0;

   tb_clock u_clk (.clk(clk));

   serial_core_top u_dut (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ins_req  (i_ins_req),
      .i_ins_data (i_ins_data),
      .o_ins_ack  (o_ins_ack),
      .o_res_req  (o_res_req),
      .o_res_rd   (o_res_rd),
      .o_res_data (o_res_data),
      .i_res_ack  (i_res_ack)
   );

   task automatic step();
      @(posedge clk);
      #1;   // drive and sample just after the edge
   endtask

   task automatic check_value(input string name, input rv_serial_pkg::word_t expected,
                              input rv_serial_pkg::word_t actual);
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
      end
   endtask

   task automatic end_run();
      int total;
      total = errors + u_dut.u_chk.fails;
      $display("closing: %0d errors (%0d assertion failures), %0d sent, %0d received",
               total, u_dut.u_chk.fails, sent, received);
      if (total == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   endtask

   // four-phase source, expected pair queued before req goes up
   task automatic send_instr(input rv_serial_pkg::word_t instr, input rv_serial_pkg::reg_addr_t rd,
                             input rv_serial_pkg::word_t value, input string name);
      exp_val_q.push_back(value);
      exp_rd_q.push_back(rd);
      exp_name_q.push_back(name);
      if (rd != 5'd0)
         model_regs[rd] = value;
      sent++;
      i_ins_data = instr;
      i_ins_req  = 1'b1;
      do
         step();
      while (!o_ins_ack);
      i_ins_req = 1'b0;
      do
         step();
      while (o_ins_ack);
   endtask

   task automatic op_imm(input logic [2:0] f3, input rv_serial_pkg::reg_addr_t rd,
                         input rv_serial_pkg::reg_addr_t rs1, input logic [11:0] imm,
                         input string name);
      rv_serial_pkg::word_t a;
      rv_serial_pkg::word_t b;
      rv_serial_pkg::word_t r;
      a = model_regs[rs1];
      b = {{20{imm[11]}}, imm};
      case (f3)
         3'b100:  r = a ^ b;
         3'b110:  r = a | b;
         3'b111:  r = a & b;
         default: r = a + b;   // addi
      endcase
      send_instr({imm, rs1, f3, rd, 7'b0010011}, rd, r, name);
   endtask

   task automatic op_reg(input bit is_sub, input logic [2:0] f3, input rv_serial_pkg::reg_addr_t rd,
                         input rv_serial_pkg::reg_addr_t rs1, input rv_serial_pkg::reg_addr_t rs2,
                         input string name);
      rv_serial_pkg::word_t a;
      rv_serial_pkg::word_t b;
      rv_serial_pkg::word_t r;
      a = model_regs[rs1];
      b = model_regs[rs2];
      case (f3)
         3'b100:  r = a ^ b;
         3'b110:  r = a | b;
         3'b111:  r = a & b;
         default: r = is_sub ? a - b : a + b;
      endcase
      send_instr({1'b0, is_sub, 5'd0, rs2, rs1, f3, rd, 7'b0110011}, rd, r, name);
   endtask

   task automatic load_upper(input rv_serial_pkg::reg_addr_t rd, input logic [19:0] imm,
                             input string name);
      send_instr({imm, rd, 7'b0110111}, rd, {imm, 12'h000}, name);
   endtask

   // kind 0 op-imm, 1 op, 2 lui; rd_mode 0 nonzero rd, 1 any rd, 2 x0
   task automatic random_instr(input int unsigned kind, input int rd_mode, input string name);
      logic [2:0]               imm_f3 [4];
      logic [2:0]               reg_f3 [5];
      int unsigned              sel;
      rv_serial_pkg::reg_addr_t rd;
      rv_serial_pkg::reg_addr_t rs1;
      rv_serial_pkg::reg_addr_t rs2;
      imm_f3 = '{3'b000, 3'b100, 3'b110, 3'b111};
      reg_f3 = '{3'b000, 3'b000, 3'b100, 3'b110, 3'b111};   // add sub xor or and
      if (rd_mode == 2)
         rd = 5'd0;
      else if (rd_mode == 0)
         rd = 5'(1 + $urandom % 31);
      else
         rd = 5'($urandom);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      if ($urandom % 4 == 0)
         rs1 = rd;   // source overwritten in place
      case (kind)
         0: op_imm(imm_f3[$urandom % 4], rd, rs1, 12'($urandom), name);
         1: begin
            sel = $urandom % 5;
            op_reg(sel == 1, reg_f3[sel], rd, rs1, rs2, name);
         end
         default: load_upper(rd, 20'($urandom), name);
      endcase
   endtask

   initial begin : stimulus
      void'($urandom(32'heed4));
      i_rst      = 1'b1;
      i_ins_req  = 1'b0;
      i_ins_data = '0;
      i_res_ack  = 1'b0;
      foreach (model_regs[r])
         model_regs[r] = '0;
      repeat (N_INSTR)
         delay_q.push_back($urandom % 8);
      repeat (4) step();
      i_rst = 1'b0;
      for (int r = 1; r < 32; r++)
         op_imm(3'b000, 5'(r), 5'd0, 12'($urandom), $sformatf("init x%0d", r));
      // carry through all 32 bits, negative difference
      op_imm(3'b000, 5'd5, 5'd0, 12'hfff, "carry setup x5");
      op_imm(3'b000, 5'd6, 5'd0, 12'h001, "carry setup x6");
      op_reg(1'b0, 3'b000, 5'd7, 5'd5, 5'd6, "add carry out");
      op_reg(1'b1, 3'b000, 5'd8, 5'd0, 5'd6, "sub negative");
      for (int i = 0; i < 50; i++)
         random_instr(0, 0, $sformatf("opimm %0d", i));
      for (int i = 0; i < 50; i++)
         random_instr(1, 0, $sformatf("op %0d", i));
      for (int i = 0; i < 20; i++)
         random_instr(2, 0, $sformatf("lui %0d", i));
      for (int i = 0; i < 10; i++)
         random_instr($urandom % 3, 2, $sformatf("x0 write %0d", i));
      op_reg(1'b0, 3'b000, 5'd9, 5'd0, 5'd0, "x0 read add");
      op_imm(3'b000, 5'd10, 5'd0, 12'h000, "x0 read addi");
      op_reg(1'b0, 3'b110, 5'd11, 5'd0, 5'd3, "x0 read or");
      op_reg(1'b1, 3'b000, 5'd12, 5'd4, 5'd0, "x0 read sub");
      op_reg(1'b0, 3'b100, 5'd13, 5'd0, 5'd0, "x0 read xor");
      for (int i = 0; i < 30; i++)
         random_instr($urandom % 3, 1, $sformatf("mixed %0d", i));
      while (received < sent)
         step();
      repeat (20) step();   // window for a stray extra result
      end_run();
   end

   // result sink with random ack delay
   initial begin : responder
      int unsigned delay;
      string       name;
      forever begin
         step();
         if (o_res_req) begin
            delay = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
            repeat (delay) step();
            if (exp_val_q.size() == 0) begin
               errors++;
               $display("ERROR: result for x%0d arrived with no instruction outstanding",
                        o_res_rd);
            end else begin
               name = exp_name_q.pop_front();
               check_value(name, exp_val_q.pop_front(), o_res_data);
               check_value({name, " rd"}, 32'(exp_rd_q.pop_front()), 32'(o_res_rd));
            end
            received++;
            i_res_ack = 1'b1;
            do
               step();
            while (o_res_req);
            i_res_ack = 1'b0;
         end
      end
   end

   initial begin : watchdog
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      errors++;
      $display("ERROR: run timed out after %0d cycles, %0d of %0d results received",
               cycles, received, sent);
      end_run();
   end

endmodule

// ==== tests/serial_core_chk.sv ====
`timescale 1ns/1ps

module serial_core_chk (
   input logic                     clk,
   input logic                     i_rst,
   input logic                     i_ins_req,
   input logic                     o_ins_ack,
   input logic                     o_res_req,
   input rv_serial_pkg::reg_addr_t o_res_rd,
   input rv_serial_pkg::word_t     o_res_data,
   input logic                     i_res_ack,
   input logic                     i_take
);

   int fails = 0;   // failed assertions

   // source may drop req as soon as it sees ack
   ins_req_held: assert property (@(posedge clk) disable iff (i_rst)
      i_ins_req && !o_ins_ack |=> i_ins_req || o_ins_ack)
      else begin
         fails++;
         $error("instruction req dropped before ack");
      end

   res_req_held: assert property (@(posedge clk) disable iff (i_rst)
      o_res_req && !i_res_ack |=> o_res_req)
      else begin
         fails++;
         $error("result req dropped before ack");
      end

   // rd and data frozen for the whole request
   res_data_stable: assert property (@(posedge clk) disable iff (i_rst)
      o_res_req |=> !o_res_req || ($stable(o_res_data) && $stable(o_res_rd)))
      else begin
         fails++;
         $error("result data changed while req high");
      end

   idle_after_reset: assert property (@(posedge clk)
      $fell(i_rst) |-> !o_ins_ack && !o_res_req)
      else begin
         fails++;
         $error("ack or req high right after reset");
      end

   take_to_req: assert property (@(posedge clk) disable iff (i_rst)
      i_take |-> ##33 $rose(o_res_req))
      else begin
         fails++;
         $error("result req not 33 cycles after take");
      end

endmodule

bind serial_core_top serial_core_chk u_chk (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_ins_req  (i_ins_req),
   .o_ins_ack  (o_ins_ack),
   .o_res_req  (o_res_req),
   .o_res_rd   (o_res_rd),
   .o_res_data (o_res_data),
   .i_res_ack  (i_res_ack),
   .i_take     (take)
);

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

endmodule

// ==== design/serial_core_top.sv ====
`timescale 1ns/1ps

module serial_core_top (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic                     i_ins_req,
   input  rv_serial_pkg::word_t     i_ins_data,
   output logic                     o_ins_ack,
   output logic                     o_res_req,
   output rv_serial_pkg::reg_addr_t o_res_rd,
   output rv_serial_pkg::word_t     o_res_data,
   input  logic                     i_res_ack
);

   logic                 instr_valid;
   rv_serial_pkg::word_t instr;
   logic                 take;
   logic                 res_free;
   logic                 rs1_bit;
   logic                 rs2_bit;
   logic                 rd_bit;     // to regfile and result port

   serial_ctrl_if u_ctrl ();

   instr_fetch u_fetch (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ins_req  (i_ins_req),
      .i_ins_data (i_ins_data),
      .o_ins_ack  (o_ins_ack),
      .o_valid    (instr_valid),
      .o_instr    (instr),
      .i_take     (take)
   );

   serial_decode u_decode (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_valid    (instr_valid),
      .i_instr    (instr),
      .o_take     (take),
      .i_res_free (res_free),
      .ctrl       (u_ctrl.dec)
   );

   serial_regfile u_regfile (
      .clk       (clk),
      .ctrl      (u_ctrl.rf),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu u_alu (
      .clk       (clk),
      .ctrl      (u_ctrl.alu),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .o_rd_bit  (rd_bit)
   );

   result_port u_result (
      .clk        (clk),
      .i_rst      (i_rst),
      .ctrl       (u_ctrl.res),
      .i_rd_bit   (rd_bit),
      .o_free     (res_free),
      .o_res_req  (o_res_req),
      .o_res_rd   (o_res_rd),
      .o_res_data (o_res_data),
      .i_res_ack  (i_res_ack)
   );

endmodule

// ==== design/result_port.sv ====
`timescale 1ns/1ps

module result_port (
   input  logic                     clk,
   input  logic                     i_rst,
   serial_ctrl_if.res               ctrl,
   input  logic                     i_rd_bit,
   output logic                     o_free,
   output logic                     o_res_req,
   output rv_serial_pkg::reg_addr_t o_res_rd,
   output rv_serial_pkg::word_t     o_res_data,
   input  logic                     i_res_ack
);

   rv_serial_pkg::res_state_e state;
   logic                      collecting;

   assign collecting = (state == rv_serial_pkg::RES_COLLECT);
   assign o_free     = collecting;
   assign o_res_req  = (state == rv_serial_pkg::RES_REQ);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= rv_serial_pkg::RES_COLLECT;
      end else begin
         case (state)
            rv_serial_pkg::RES_COLLECT: begin
               if (ctrl.done)
                  state <= rv_serial_pkg::RES_REQ;
            end
            rv_serial_pkg::RES_REQ: begin
               if (i_res_ack)
                  state <= rv_serial_pkg::RES_WAIT_DROP;  // req falls next cycle
            end
            rv_serial_pkg::RES_WAIT_DROP: begin
               if (!i_res_ack)
                  state <= rv_serial_pkg::RES_COLLECT;
            end
            default: state <= rv_serial_pkg::RES_COLLECT;
         endcase
      end
   end

   // lsb first, so bits enter at the top and move down
   always_ff @(posedge clk) begin
      if (collecting && ctrl.en)
         o_res_data <= {i_rd_bit, o_res_data[31:1]};
      if (collecting && ctrl.done)
         o_res_rd <= ctrl.rd_addr;
   end

endmodule

// ==== design/serial_alu.sv ====
`timescale 1ns/1ps

module serial_alu (
   input  logic        clk,
   serial_ctrl_if.alu  ctrl,
   input  logic        i_rs1_bit,
   input  logic        i_rs2_bit,
   output logic        o_rd_bit
);

   logic op_a;
   logic op_b;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic bool_res;

   assign op_a = ctrl.op_a_zero ? 1'b0 : i_rs1_bit;
   assign op_b = (ctrl.op_b_imm ? ctrl.imm_bit : i_rs2_bit) ^ ctrl.sub; // ~b for sub

   // sub adds ~b + 1, the +1 enters as carry at bit 0
   assign carry_in = (ctrl.cnt == '0) ? ctrl.sub : carry_q;
   assign sum      = op_a ^ op_b ^ carry_in;

   always_ff @(posedge clk) begin
      carry_q <= (op_a & op_b) | (carry_in & (op_a ^ op_b));
   end

   always_comb begin
      case (ctrl.bool_op)
         rv_serial_pkg::BOOL_OR:  bool_res = op_a | op_b;
         rv_serial_pkg::BOOL_AND: bool_res = op_a & op_b;
         default:                 bool_res = op_a ^ op_b;  // xor
      endcase
   end

   assign o_rd_bit = (ctrl.alu_sel == rv_serial_pkg::ALU_SEL_BOOL) ? bool_res : sum;

endmodule

// ==== design/serial_regfile.sv ====
`timescale 1ns/1ps

module serial_regfile (
   input  logic        clk,
   serial_ctrl_if.rf   ctrl,
   input  logic        i_rd_bit,
   output logic        o_rs1_bit,
   output logic        o_rs2_bit
);

   // x1..x31, x0 has no storage
   rv_serial_pkg::word_t regs [1:31];

   logic rs1_zero;
   logic rs2_zero;

   assign rs1_zero = (ctrl.rs1_addr == '0);
   assign rs2_zero = (ctrl.rs2_addr == '0);

   // bit k is read in the same cycle it is overwritten,
   // so the old value reaches the alu even when rd is a source
   always_comb begin
      if (rs1_zero)
         o_rs1_bit = 1'b0;
      else
         o_rs1_bit = regs[ctrl.rs1_addr][ctrl.cnt];
   end

   always_comb begin
      if (rs2_zero)
         o_rs2_bit = 1'b0;
      else
         o_rs2_bit = regs[ctrl.rs2_addr][ctrl.cnt];
   end

   always_ff @(posedge clk) begin
      if (ctrl.rd_en)                              // never set for x0
         regs[ctrl.rd_addr][ctrl.cnt] <= i_rd_bit;
   end

endmodule

// ==== design/serial_decode.sv ====
`timescale 1ns/1ps

module serial_decode (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_valid,
   input  rv_serial_pkg::word_t i_instr,
   output logic                 o_take,
   input  logic                 i_res_free,
   serial_ctrl_if.dec           ctrl
);

   rv_serial_pkg::dec_state_e state;
   rv_serial_pkg::bit_cnt_t   cnt;
   rv_serial_pkg::opcode_t    opcode;
   rv_serial_pkg::opcode_t    new_opcode;
   rv_serial_pkg::word_t      imm;
   rv_serial_pkg::reg_addr_t  rd;
   rv_serial_pkg::reg_addr_t  rs1;
   rv_serial_pkg::reg_addr_t  rs2;
   logic [2:0]                funct3;
   logic                      bit30;
   logic                      run;
   logic                      is_op;
   logic                      is_opimm;
   logic                      is_lui;

   assign run        = (state == rv_serial_pkg::DEC_RUN);
   assign o_take     = (state == rv_serial_pkg::DEC_IDLE) && i_valid && i_res_free;
   assign new_opcode = i_instr[6:2];

   assign is_op    = (opcode == rv_serial_pkg::OPC_OP);
   assign is_opimm = (opcode == rv_serial_pkg::OPC_OPIMM);
   assign is_lui   = (opcode == rv_serial_pkg::OPC_LUI);

   // sequencer, 32 run cycles per instruction
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= rv_serial_pkg::DEC_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            rv_serial_pkg::DEC_IDLE: begin
               cnt <= '0;
               if (o_take)
                  state <= rv_serial_pkg::DEC_RUN;
            end
            rv_serial_pkg::DEC_RUN: begin
               cnt <= cnt + 5'd1;      // wraps to 0 after bit 31
               if (cnt == rv_serial_pkg::LAST_BIT)
                  state <= rv_serial_pkg::DEC_IDLE;
            end
            default: state <= rv_serial_pkg::DEC_IDLE;
         endcase
      end
   end

   // instruction fields and immediate
   always_ff @(posedge clk) begin
      if (o_take) begin
         opcode <= new_opcode;
         rd     <= i_instr[11:7];
         rs1    <= i_instr[19:15];
         rs2    <= i_instr[24:20];
         funct3 <= i_instr[14:12];
         bit30  <= i_instr[30];
         if (new_opcode == rv_serial_pkg::OPC_LUI)
            imm <= {i_instr[31:12], 12'd0};           // u-type
         else
            imm <= {{20{i_instr[31]}}, i_instr[31:20]}; // i-type, sign extended
      end else if (run) begin
         imm <= {imm[0], imm[31:1]};  // next bit into imm[0]
      end
   end

   assign ctrl.en        = run;
   assign ctrl.cnt       = cnt;
   assign ctrl.rs1_addr  = rs1;
   assign ctrl.rs2_addr  = rs2;
   assign ctrl.rd_addr   = rd;
   assign ctrl.rd_en     = run && (rd != '0) && (is_op || is_opimm || is_lui);
   assign ctrl.imm_bit   = imm[0];
   assign ctrl.op_b_imm  = is_opimm || is_lui;
   assign ctrl.op_a_zero = is_lui;
   assign ctrl.sub       = is_op && bit30;

   // funct3 of lui is immediate bits, so lui always adds
   assign ctrl.alu_sel   = (!is_lui && (funct3 != 3'b000)) ? rv_serial_pkg::ALU_SEL_BOOL
                                                          : rv_serial_pkg::ALU_SEL_ADD;
   assign ctrl.bool_op   = funct3[1:0];
   assign ctrl.done      = run && (cnt == rv_serial_pkg::LAST_BIT);

endmodule

// ==== design/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_ins_req,
   input  rv_serial_pkg::word_t i_ins_data,
   output logic                 o_ins_ack,
   output logic                 o_valid,
   output rv_serial_pkg::word_t o_instr,
   input  logic                 i_take
);

   rv_serial_pkg::fetch_state_e state;
   logic                        req_q;     // sampled request
   logic                        capture;

   // only one word held at a time
   assign capture = (state == rv_serial_pkg::FETCH_EMPTY) && req_q && !o_valid;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state     <= rv_serial_pkg::FETCH_EMPTY;
         req_q     <= 1'b0;
         o_ins_ack <= 1'b0;
         o_valid   <= 1'b0;
      end else begin
         req_q <= i_ins_req;
         if (i_take)
            o_valid <= 1'b0;           // decoder consumed it
         case (state)
            rv_serial_pkg::FETCH_EMPTY: begin
               if (capture) begin
                  o_valid <= 1'b1;
                  state   <= rv_serial_pkg::FETCH_FULL;
               end
            end
            rv_serial_pkg::FETCH_FULL: begin
               o_ins_ack <= 1'b1;      // ack one cycle after capture
               state     <= rv_serial_pkg::FETCH_WAIT_DROP;
            end
            rv_serial_pkg::FETCH_WAIT_DROP: begin
               if (!req_q) begin
                  o_ins_ack <= 1'b0;
                  state     <= rv_serial_pkg::FETCH_EMPTY;
               end
            end
            default: state <= rv_serial_pkg::FETCH_EMPTY;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture)
         o_instr <= i_ins_data;
   end

endmodule

// ==== design/serial_ctrl_if.sv ====
`timescale 1ns/1ps

interface serial_ctrl_if;

   logic                     en;          // run cycles only
   rv_serial_pkg::bit_cnt_t  cnt;
   rv_serial_pkg::reg_addr_t rs1_addr;
   rv_serial_pkg::reg_addr_t rs2_addr;
   rv_serial_pkg::reg_addr_t rd_addr;
   logic                     rd_en;
   logic                     imm_bit;
   logic                     op_b_imm;
   logic                     op_a_zero;   // lui
   logic                     sub;
   rv_serial_pkg::alu_sel_t  alu_sel;
   rv_serial_pkg::bool_op_t  bool_op;
   logic                     done;        // bit 31 cycle

   modport dec (output en, cnt, rs1_addr, rs2_addr, rd_addr, rd_en, imm_bit,
                output op_b_imm, op_a_zero, sub, alu_sel, bool_op, done);
   modport rf  (input cnt, rs1_addr, rs2_addr, rd_addr, rd_en);
   modport alu (input cnt, imm_bit, op_b_imm, op_a_zero, sub, alu_sel, bool_op);
   modport res (input en, rd_addr, done);

endinterface

// ==== design/rv_serial_pkg.sv ====
package rv_serial_pkg;

   localparam int WORD_W = 32;
   localparam int REG_W  = 5;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_addr_t;
   typedef logic [4:0]        bit_cnt_t;   // one of 32 bit positions
   typedef logic [4:0]        opcode_t;    // instr[6:2]
   typedef logic              alu_sel_t;
   typedef logic [1:0]        bool_op_t;   // funct3[1:0]

   localparam bit_cnt_t LAST_BIT = bit_cnt_t'(WORD_W - 1);

   localparam opcode_t OPC_OP    = 5'b01100;
   localparam opcode_t OPC_OPIMM = 5'b00100;
   localparam opcode_t OPC_LUI   = 5'b01101;

   localparam alu_sel_t ALU_SEL_ADD  = 1'b0;
   localparam alu_sel_t ALU_SEL_BOOL = 1'b1;

   localparam bool_op_t BOOL_XOR = 2'b00;
   localparam bool_op_t BOOL_OR  = 2'b10;
   localparam bool_op_t BOOL_AND = 2'b11;

   typedef enum logic [1:0] {FETCH_EMPTY, FETCH_FULL, FETCH_WAIT_DROP} fetch_state_e;
   typedef enum logic {DEC_IDLE, DEC_RUN} dec_state_e;
   typedef enum logic [1:0] {RES_COLLECT, RES_REQ, RES_WAIT_DROP} res_state_e;

endpackage
